/* include/kbd_macros.svh */
`ifndef KBD_MACROS_SVH
`define KBD_MACROS_SVH

// ps2 scan code prefixes
`define PS2_PREFIX_EXT      8'hE0
`define PS2_PREFIX_BREAK    8'hF0

// shift keys, 9-bit codes with extended flag clear
`define KEY_LSHIFT          9'h012
`define KEY_RSHIFT          9'h059

// nibble value shown as a dark digit
`define KBD_BLANK_NIBBLE    4'hF

// cycles of ps2_clk held high mid-frame before the frame is dropped
`define PS2_IDLE_TIMEOUT    16'd4000

// scan divider width, one digit step per 2^N clocks
`define KBD_SCAN_DIV_BITS   16

`endif

/* verilog/kbd_pkg.sv */
`default_nettype none

package kbd_pkg;

    typedef logic [7:0]   ps2_byte_t;   // raw data byte from a frame
    typedef logic [8:0]   key_code_t;   // {extended, scan code}
    typedef logic [511:0] key_map_t;    // one held bit per key code
    typedef logic [3:0]   digit_val_t;  // 0..9 or blank
    typedef logic [15:0]  digit_reg_t;  // four digits, leftmost in 15..12
    typedef logic [6:0]   seg_t;        // active low, bit 0 = a
    typedef logic [3:0]   anode_t;      // active low, bit 3 = leftmost

    typedef enum logic [1:0] {
        rx_idle,
        rx_shift,
        rx_check
    } rx_state_e;

    typedef enum logic [1:0] {
        dec_base,
        dec_ext,
        dec_brk,
        dec_ext_brk
    } dec_state_e;

endpackage

`default_nettype wire

/* verilog/ps2_rx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kbd_macros.svh"

module ps2_rx (
    input  wire                clk,
    input  wire                rst,
    input  wire                ps2_clk,
    input  wire                ps2_data,
    output logic               byte_valid,
    output kbd_pkg::ps2_byte_t rx_byte
);
    import kbd_pkg::*;

    logic [1:0]  clk_sync;    // two-stage synchronizer for ps2_clk
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        fall_r;      // registered falling edge
    logic        data_r;      // data bit aligned with fall_r
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic [15:0] idle_cnt;
    logic        frame_ok;
    rx_state_e   state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;   // lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
            fall_r    <= 1'b0;
            data_r    <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
            fall_r    <= clk_prev & ~clk_sync[1];
            data_r    <= data_sync[1];
        end
    end

    // start low, stop high, odd parity over data plus parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= rx_idle;
            bit_cnt    <= 4'd0;
            idle_cnt   <= 16'd0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    idle_cnt <= 16'd0;
                    if (fall_r) begin
                        bit_cnt <= 4'd1;   // start bit taken
                        state   <= rx_shift;
                    end
                end
                rx_shift: begin
                    if (fall_r) begin
                        bit_cnt  <= bit_cnt + 4'd1;
                        idle_cnt <= 16'd0;
                        if (bit_cnt == 4'd10) begin
                            state <= rx_check;   // stop bit just shifted in
                        end
                    end else if (idle_cnt == `PS2_IDLE_TIMEOUT - 16'd1) begin
                        state <= rx_idle;   // device went quiet, drop partial frame
                    end else if (clk_sync[1]) begin
                        idle_cnt <= idle_cnt + 16'd1;
                    end else begin
                        idle_cnt <= 16'd0;
                    end
                end
                rx_check: begin
                    byte_valid <= frame_ok;
                    state      <= rx_idle;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (fall_r && state != rx_check) begin
            frame <= {data_r, frame[10:1]};
        end
        if (state == rx_check) begin
            rx_byte <= frame[8:1];
        end
    end

    // ps2 bit rate is far below clk, back-to-back bytes are impossible
    a_no_double_valid: assert property (
        @(posedge clk) disable iff (rst) byte_valid |=> !byte_valid
    );

endmodule

`default_nettype wire

/* verilog/key_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kbd_macros.svh"

module key_decoder (
    input  wire                clk,
    input  wire                rst,
    input  wire                byte_valid,
    input  wire kbd_pkg::ps2_byte_t rx_byte,
    output logic               key_press,
    output kbd_pkg::key_code_t key_code,
    output kbd_pkg::key_map_t  key_down
);
    import kbd_pkg::*;

    dec_state_e state;
    logic       is_ext;
    logic       is_brk;
    logic       is_prefix;
    key_code_t  code;

    assign is_ext    = (state == dec_ext) || (state == dec_ext_brk);
    assign is_brk    = (state == dec_brk) || (state == dec_ext_brk);
    assign is_prefix = (rx_byte == `PS2_PREFIX_EXT) || (rx_byte == `PS2_PREFIX_BREAK);
    assign code      = {is_ext, rx_byte};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= dec_base;
            key_press <= 1'b0;
            key_down  <= '0;
        end else begin
            key_press <= 1'b0;
            if (byte_valid) begin
                if (rx_byte == `PS2_PREFIX_EXT) begin
                    state <= is_brk ? dec_ext_brk : dec_ext;
                end else if (rx_byte == `PS2_PREFIX_BREAK) begin
                    state <= is_ext ? dec_ext_brk : dec_brk;
                end else begin
                    state <= dec_base;   // code byte ends the sequence
                    if (is_brk) begin
                        key_down[code] <= 1'b0;
                    end else begin
                        key_down[code] <= 1'b1;
                        key_press      <= ~key_down[code];   // typematic repeat stays quiet
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && !is_prefix) begin
            key_code <= code;
        end
    end

    // a press is only reported for a key that was up one cycle earlier
    a_press_was_up: assert property (
        @(posedge clk) disable iff (rst)
        key_press |-> key_down[key_code] &&
                      (($past(key_down) & (key_map_t'(1) << key_code)) == '0)
    );

endmodule

`default_nettype wire

/* verilog/digit_entry.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kbd_macros.svh"

module digit_entry (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     key_press,
    input  wire kbd_pkg::key_code_t key_code,
    input  wire kbd_pkg::key_map_t  key_down,
    output kbd_pkg::digit_reg_t     nums
);
    import kbd_pkg::*;

    digit_val_t key_val;
    logic       shift_held;

    // main row and keypad give the same value, extended codes fall through
    always_comb begin
        case (key_code)
            9'h045, 9'h070: key_val = 4'd0;
            9'h016, 9'h069: key_val = 4'd1;
            9'h01E, 9'h072: key_val = 4'd2;
            9'h026, 9'h07A: key_val = 4'd3;
            9'h025, 9'h06B: key_val = 4'd4;
            9'h02E, 9'h073: key_val = 4'd5;
            9'h036, 9'h074: key_val = 4'd6;
            9'h03D, 9'h06C: key_val = 4'd7;
            9'h03E, 9'h075: key_val = 4'd8;
            9'h046, 9'h07D: key_val = 4'd9;
            default:        key_val = `KBD_BLANK_NIBBLE;
        endcase
    end

    assign shift_held = key_down[`KEY_LSHIFT] | key_down[`KEY_RSHIFT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nums <= {4{`KBD_BLANK_NIBBLE}};   // all digits dark
        end else if (key_press && key_val != `KBD_BLANK_NIBBLE) begin
            if (shift_held) begin
                nums <= {nums[11:0], key_val};   // enter at the right
            end else begin
                nums <= {key_val, nums[15:4]};   // enter at the left
            end
        end
    end

    function automatic logic nums_ok(input digit_reg_t value);
        logic       ok;
        digit_val_t nib;
        int         i;
        ok = 1'b1;
        for (i = 0; i < 4; i++) begin
            nib = value[i*4 +: 4];
            if (nib > 4'd9 && nib != `KBD_BLANK_NIBBLE) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // only decoded digits and blanks ever reach the display register
    a_nums_legal: assert property (
        @(posedge clk) disable iff (rst) nums_ok(nums)
    );

endmodule

`default_nettype wire

/* verilog/seg_scan.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kbd_macros.svh"

module seg_scan #(
    parameter int SCAN_DIV_BITS = `KBD_SCAN_DIV_BITS
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire kbd_pkg::digit_reg_t nums,
    output kbd_pkg::anode_t          digit,
    output kbd_pkg::seg_t            display
);
    import kbd_pkg::*;

    logic [SCAN_DIV_BITS-1:0] div_cnt;
    logic                     step;
    logic [1:0]               sel;       // digit being loaded next
    digit_val_t               cur_nib;
    seg_t                     cur_seg;

    assign step    = &div_cnt;
    assign cur_nib = nums[sel*4 +: 4];

    always_comb begin
        case (cur_nib)
            4'd0:              cur_seg = 7'h40;
            4'd1:              cur_seg = 7'h79;
            4'd2:              cur_seg = 7'h24;
            4'd3:              cur_seg = 7'h30;
            4'd4:              cur_seg = 7'h19;
            4'd5:              cur_seg = 7'h12;
            4'd6:              cur_seg = 7'h02;
            4'd7:              cur_seg = 7'h78;
            4'd8:              cur_seg = 7'h00;
            4'd9:              cur_seg = 7'h10;
            `KBD_BLANK_NIBBLE: cur_seg = 7'h7F;   // dark
            default:           cur_seg = 7'h3F;   // dash, segment g only
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sel     <= 2'd3;      // leftmost first
            digit   <= 4'b1111;   // nothing lit until first step
            display <= 7'h7F;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (step) begin
                digit   <= ~(4'b0001 << sel);
                display <= cur_seg;
                sel     <= sel - 2'd1;   // 3, 2, 1, 0, wraps
            end
        end
    end

    // once scanning starts exactly one anode stays low
    a_one_anode: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(~digit) |=> $onehot(~digit)
    );

endmodule

`default_nettype wire

/* verilog/kbd_digit_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kbd_macros.svh"

module kbd_digit_top #(
    parameter int SCAN_DIV_BITS = `KBD_SCAN_DIV_BITS
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  ps2_clk,
    input  wire                  ps2_data,
    output wire kbd_pkg::anode_t digit,
    output wire kbd_pkg::seg_t   display
);
    import kbd_pkg::*;

    wire        byte_valid;
    ps2_byte_t  rx_byte;
    wire        key_press;
    key_code_t  key_code;
    key_map_t   key_down;
    digit_reg_t nums;

    ps2_rx u_ps2_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    key_decoder u_key_decoder (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .key_press  (key_press),
        .key_code   (key_code),
        .key_down   (key_down)
    );

    digit_entry u_digit_entry (
        .clk       (clk),
        .rst       (rst),
        .key_press (key_press),
        .key_code  (key_code),
        .key_down  (key_down),
        .nums      (nums)
    );

    seg_scan #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_seg_scan (
        .clk     (clk),
        .rst     (rst),
        .nums    (nums),
        .digit   (digit),
        .display (display)
    );

endmodule

`default_nettype wire

/* verification/kbd_digit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kbd_macros.svh"

module kbd_digit_tb;
    import kbd_pkg::*;

    localparam int HALF_BIT    = 20;                  // ps2_clk half-period in clk cycles
    localparam int FRAME_GAP   = 40;                  // idle clocks after each frame
    localparam int READ_LIMIT  = 8 * 16;              // scan step is 2^4 clocks
    localparam int MAX_FRAMES  = 90;
    localparam int MAX_READS   = 24;
    localparam int FRAME_CYCLES = 11 * 2 * HALF_BIT + FRAME_GAP;
    localparam int WATCHDOG_CYCLES =
        2 * (16 + MAX_FRAMES * FRAME_CYCLES + MAX_READS * READ_LIMIT);

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    anode_t     digit;
    seg_t       display;

    logic [15:0]  exp_nums;     // model of the digit register
    logic [511:0] held;         // keys the model believes are down

    kbd_digit_top #(
        .SCAN_DIV_BITS (4)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .digit    (digit),
        .display  (display)
    );

    always #50 clk = ~clk;

    // segments back to a nibble, active low with bit 0 = a
    function automatic logic [3:0] seg_to_nibble(input seg_t seg);
        case (seg)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0010000: return 4'd9;
            7'b1111111: return 4'hF;   // blank
            default:    return 4'hE;   // never a legal display value
        endcase
    endfunction

    // digit value a key should enter, F for anything else
    function automatic logic [3:0] key_value(input logic [8:0] code);
        case (code)
            9'h045, 9'h070: return 4'd0;
            9'h016, 9'h069: return 4'd1;
            9'h01E, 9'h072: return 4'd2;
            9'h026, 9'h07A: return 4'd3;
            9'h025, 9'h06B: return 4'd4;
            9'h02E, 9'h073: return 4'd5;
            9'h036, 9'h074: return 4'd6;
            9'h03D, 9'h06C: return 4'd7;
            9'h03E, 9'h075: return 4'd8;
            9'h046, 9'h07D: return 4'd9;
            default:        return 4'hF;
        endcase
    endfunction

    task automatic send_byte(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};   // stop, odd parity, data, start
        for (i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b1;
        end
        repeat (FRAME_GAP) @(negedge clk);
    endtask

    task automatic press_key(input logic [8:0] code);
        logic [3:0] val;
        val = key_value(code);
        if (!held[code] && val != 4'hF) begin
            if (held[`KEY_LSHIFT] || held[`KEY_RSHIFT]) begin
                exp_nums = {exp_nums[11:0], val};
            end else begin
                exp_nums = {val, exp_nums[15:4]};
            end
        end
        held[code] = 1'b1;
        if (code[8]) begin
            send_byte(`PS2_PREFIX_EXT, 1'b0);
        end
        send_byte(code[7:0], 1'b0);
    endtask

    task automatic release_key(input logic [8:0] code);
        if (code[8]) begin
            send_byte(`PS2_PREFIX_EXT, 1'b0);
        end
        send_byte(`PS2_PREFIX_BREAK, 1'b0);
        send_byte(code[7:0], 1'b0);
        held[code] = 1'b0;
    endtask

    task automatic type_key(input logic [8:0] code);
        press_key(code);
        release_key(code);
    endtask

    // collects one fresh scan round, starting at the next anode step
    task automatic read_display(output logic [15:0] observed);
        anode_t     prev;
        logic [3:0] seen;
        int         cycles;
        int         idx;
        seen     = 4'b0000;
        observed = 16'hEEEE;
        cycles   = 0;
        @(negedge clk);
        prev = digit;
        while (seen != 4'b1111 && cycles < READ_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (digit != prev) begin
                prev = digit;
                for (idx = 0; idx < 4; idx++) begin
                    if (digit == ~(4'b0001 << idx)) begin
                        observed[idx*4 +: 4] = seg_to_nibble(display);
                        seen[idx] = 1'b1;
                    end
                end
            end
        end
        assert (seen == 4'b1111) else begin
            $display("display scan did not visit all four digits in time");
            $display("Simulation failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic check_display(input string name);
        logic [15:0] observed;
        read_display(observed);
        assert (observed == exp_nums) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp_nums, observed);
            $display("Simulation failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic test_reset_blank();
        int i;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (digit == 4'b1111) else begin
                $display("[ERROR] reset_blank: expected 1111, actual %b", digit);
                $display("Simulation failed");
                $fatal(1, "stopping on first error");
            end
        end
        check_display("reset_blank");
    endtask

    task automatic test_left_entry();
        type_key(9'h016);
        type_key(9'h01E);
        type_key(9'h026);
        check_display("left_entry");   // 3 2 1 blank
    endtask

    task automatic test_shift_entry();
        press_key(`KEY_LSHIFT);
        type_key(9'h025);
        type_key(9'h02E);
        release_key(`KEY_LSHIFT);
        check_display("lshift_entry");
        press_key(`KEY_RSHIFT);
        type_key(9'h036);
        release_key(`KEY_RSHIFT);
        check_display("rshift_entry");
        type_key(9'h03D);
        check_display("unshifted_again");
    endtask

    task automatic test_keypad();
        logic [8:0] pad [10];
        int         i;
        pad = '{9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
                9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D};
        for (i = 0; i < 10; i++) begin
            type_key(pad[i]);
            check_display($sformatf("keypad_%0d", i));
        end
        type_key(9'h170);   // E0 70, extended so no digit
        type_key(9'h169);
        check_display("keypad_extended");
        type_key(9'h01C);
        type_key(9'h05A);
        check_display("non_digit");
    endtask

    task automatic test_typematic();
        press_key(9'h03E);
        press_key(9'h03E);   // repeat make, no break
        check_display("typematic_once");
        release_key(9'h03E);
        type_key(9'h03E);
        check_display("typematic_again");
    endtask

    task automatic test_bad_parity();
        send_byte(8'h16, 1'b1);   // dropped frame, model unchanged
        type_key(9'h046);
        check_display("bad_parity");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        exp_nums    = 16'hFFFF;
        held        = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        test_reset_blank();
        test_left_entry();
        test_shift_entry();
        test_keypad();
        test_typematic();
        test_bad_parity();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
verilog/kbd_pkg.sv
verilog/ps2_rx.sv
verilog/key_decoder.sv
verilog/digit_entry.sv
verilog/seg_scan.sv
verilog/kbd_digit_top.sv
verification/kbd_digit_tb.sv
